// ==== bench/dcache_checker.sv ====
// checker with a reference model of the four ways, comparing load and writeback outputs of the DUT
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_checker
(
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 rd_valid_i,
  input  dcache_pkg::dc_addr_t rd_addr_i,
  input  dcache_pkg::dc_hit_t  rd_hit_i,
  input  logic                 fill_valid_i,
  input  dcache_pkg::dc_way_t  fill_way_i,
  input  dcache_pkg::dc_addr_t fill_addr_i,
  input  dcache_pkg::dc_line_t fill_data_i,
  input  logic                 st_valid_i,
  input  dcache_pkg::dc_way_t  st_way_i,
  input  dcache_pkg::dc_addr_t st_addr_i,
  input  dcache_pkg::dc_strb_t st_strb_i,
  input  dcache_pkg::dc_word_t st_data_i,
  input  logic                 wb_req_i,
  input  dcache_pkg::dc_way_t  wb_way_i,
  input  dcache_pkg::dc_addr_t wb_addr_i,
  // test data expectations sampled with their request
  input  dcache_pkg::dc_word_t file_rd_exp_i,
  input  dcache_pkg::dc_line_t file_wb_exp_i,
  // observed DUT outputs
  input  logic                 dut_rd_valid_i,
  input  dcache_pkg::dc_word_t dut_rd_data_i,
  input  logic                 dut_wb_valid_i,
  input  dcache_pkg::dc_line_t dut_wb_data_i,
  output int                   rd_errs_o,
  output int                   wb_errs_o,
  output logic                 pending_o
);
  import dcache_pkg::*;

  // ways x sets x words in the order software sees the cache
  dc_word_t model [`DC_WAYS][2**`DC_SET_W][`DC_LINE_WORDS];

  // load pipe holds all ways' words at the request edge, then the hit-selected word
  logic     rd_s1;
  dc_word_t rd_s1_words [`DC_WAYS];
  dc_word_t rd_s1_file;
  logic     rd_s2;
  dc_word_t rd_s2_data;
  dc_word_t rd_s2_file;

  // edges left in the writeback window with the result due at 1
  int       wb_busy;
  dc_line_t wb_exp;
  dc_line_t wb_file;
  // last delivered line that must stay on wb_data_o
  dc_line_t wb_last;
  logic     wb_seen;

  assign pending_o = rd_s1 || rd_s2 || (wb_busy != 0);

  always @(posedge clk)
  begin
    int       n_req;
    dc_set_t  set;
    dc_word_t word;
    if (!rst_n_i)
    begin
      rd_errs_o = 0;
      wb_errs_o = 0;
      rd_s1     = 1'b0;
      rd_s2     = 1'b0;
      wb_busy   = 0;
      wb_seen   = 1'b0;
    end
    else
    begin
      // load result due at this edge
      if (dut_rd_valid_i !== rd_s2)
      begin
        $display("** Error rd_valid_o: expected 0x%0h, got 0x%0h at %0t",
                 rd_s2, dut_rd_valid_i, $time);
        rd_errs_o++;
      end
      else if (rd_s2)
      begin
        if (dut_rd_data_i !== rd_s2_data)
        begin
          $display("** Error rd_data_o: expected 0x%08h, got 0x%08h at %0t",
                   rd_s2_data, dut_rd_data_i, $time);
          rd_errs_o++;
        end
        if (dut_rd_data_i !== rd_s2_file)
        begin
          $display("** Error rd_data_o: test data expects 0x%08h, got 0x%08h at %0t",
                   rd_s2_file, dut_rd_data_i, $time);
          rd_errs_o++;
        end
      end
      // writeback pulse two edges after the accepted request
      if (dut_wb_valid_i !== (wb_busy == 1))
      begin
        $display("** Error wb_valid_o: expected 0x%0h, got 0x%0h at %0t",
                 (wb_busy == 1), dut_wb_valid_i, $time);
        wb_errs_o++;
      end
      else if (wb_busy == 1)
      begin
        if (dut_wb_data_i !== wb_exp)
        begin
          $display("** Error wb_data_o: expected 0x%032h, got 0x%032h at %0t",
                   wb_exp, dut_wb_data_i, $time);
          wb_errs_o++;
        end
        if (dut_wb_data_i !== wb_file)
        begin
          $display("** Error wb_data_o: test data expects 0x%032h, got 0x%032h at %0t",
                   wb_file, dut_wb_data_i, $time);
          wb_errs_o++;
        end
        wb_last = wb_exp;
        wb_seen = 1'b1;
      end
      else if (wb_seen && dut_wb_data_i !== wb_last)
      begin
        $display("** Error wb_data_o: expected held 0x%032h, got 0x%032h at %0t",
                 wb_last, dut_wb_data_i, $time);
        wb_errs_o++;
      end

      // hit arrives one edge after its request
      rd_s2      = rd_s1;
      rd_s2_file = rd_s1_file;
      rd_s2_data = '0;
      for (int v = 0; v < `DC_WAYS; v++)
      begin
        if (rd_hit_i[v])
          rd_s2_data = rd_s2_data | rd_s1_words[v];
      end

      // engine takes a lone strobe only outside the writeback window
      n_req = int'(fill_valid_i) + int'(st_valid_i) + int'(wb_req_i);
      if (wb_busy > 0)
        wb_busy--;
      else if (n_req == 1)
      begin
        if (fill_valid_i)
        begin
          set = fill_addr_i[`DC_ADDR_W-1:4];
          for (int w = 0; w < `DC_LINE_WORDS; w++)
            model[fill_way_i][set][w] = fill_data_i[32*w +: 32];
        end
        if (st_valid_i)
        begin
          set  = st_addr_i[`DC_ADDR_W-1:4];
          word = model[st_way_i][set][st_addr_i[3:2]];
          for (int i = 0; i < 4; i++)
          begin
            if (st_strb_i[i])
              word[8*i +: 8] = st_data_i[8*i +: 8];
          end
          model[st_way_i][set][st_addr_i[3:2]] = word;
        end
        if (wb_req_i)
        begin
          set = wb_addr_i[`DC_ADDR_W-1:4];
          for (int w = 0; w < `DC_LINE_WORDS; w++)
            wb_exp[32*w +: 32] = model[wb_way_i][set][w];
          wb_file = file_wb_exp_i;
          wb_busy = 2;
        end
      end

      // a load sees a write of the same edge
      rd_s1      = rd_valid_i;
      rd_s1_file = file_rd_exp_i;
      set        = rd_addr_i[`DC_ADDR_W-1:4];
      for (int v = 0; v < `DC_WAYS; v++)
        rd_s1_words[v] = model[v][set][rd_addr_i[3:2]];
    end
  end

endmodule

// ==== bench/dcache_testdata.txt ====
# F way addr line | S way addr strb word | W way addr expected_line | E end
# R addr hit expected chain | C way addr strb word hit expected (store and load together)
# four ways of set 0x12, word w of way v reads vwXXvw
F 0 120 0303aa030202aa020101aa010000aa00
F 1 120 1313bb131212bb121111bb111010bb10
F 2 120 2323cc232222cc222121cc212020cc20
F 3 120 3333dd333232dd323131dd313030dd30
F 1 3f0 deadbeefcafef00d0123456789abcdef
# every word with every one-hot hit, chain 1 sends the next load in the next cycle
R 120 1 0000aa00 0
R 120 2 1010bb10 0
R 120 4 2020cc20 0
R 120 8 3030dd30 0
R 124 1 0101aa01 1
R 124 2 1111bb11 1
R 124 4 2121cc21 1
R 124 8 3131dd31 0
R 128 1 0202aa02 0
R 128 2 1212bb12 0
R 128 4 2222cc22 0
R 128 8 3232dd32 0
R 12c 1 0303aa03 1
R 12c 2 1313bb13 1
R 12c 4 2323cc23 1
R 12c 8 3333dd33 0
R 3f8 2 cafef00d 0
W 0 120 0303aa030202aa020101aa010000aa00
# partial store, bytes 0 and 2
S 2 124 5 deadbeef
R 124 4 21adccef 0
W 2 120 2323cc232222cc2221adccef2020cc20
# same-cycle store and load, forwarded and not forwarded
C 1 12c 3 0badf00d 2 1313f00d
C 3 128 f 12345678 1 0202aa02
R 128 8 12345678 0
# no way hits
R 124 0 00000000 0
W 3 120 3333dd33123456783131dd313030dd30
W 1 120 1313f00d1212bb121111bb111010bb10
E

// ==== bench/tb_dcache_top.sv ====
// testbench top with clock, reset, test-data driven stimulus, checker hookup and final report
`timescale 1ns/1ps
`include "dcache_defs.svh"

module tb_dcache_top;
  import dcache_pkg::*;

  localparam int MAX_RECORDS = 1000;
  localparam int DRAIN_LIMIT = 50;

  logic     clk;
  logic     rst_n;
  logic     rd_valid;
  dc_addr_t rd_addr;
  dc_hit_t  rd_hit;
  logic     fill_valid;
  dc_way_t  fill_way;
  dc_addr_t fill_addr;
  dc_line_t fill_data;
  logic     st_valid;
  dc_way_t  st_way;
  dc_addr_t st_addr;
  dc_strb_t st_strb;
  dc_word_t st_data;
  logic     wb_req;
  dc_way_t  wb_way;
  dc_addr_t wb_addr;
  // file expectations presented with their request
  dc_word_t exp_word;
  dc_line_t exp_line;

  logic     dut_rd_valid;
  dc_word_t dut_rd_data;
  logic     dut_wb_valid;
  dc_line_t dut_wb_data;

  int       rd_errs;
  int       wb_errs;
  int       other_errs;
  logic     pending;
  integer   seed;
  // hit of last cycle's load, waiting for the next edge
  dc_hit_t  pending_hit;

  always #20 clk = ~clk;

  dcache_data_top dut0 (
    .clk(clk), .rst_n_i(rst_n),
    .rd_valid_i(rd_valid), .rd_addr_i(rd_addr), .rd_hit_i(rd_hit),
    .rd_valid_o(dut_rd_valid), .rd_data_o(dut_rd_data),
    .fill_valid_i(fill_valid), .fill_way_i(fill_way),
    .fill_addr_i(fill_addr), .fill_data_i(fill_data),
    .st_valid_i(st_valid), .st_way_i(st_way), .st_addr_i(st_addr),
    .st_strb_i(st_strb), .st_data_i(st_data),
    .wb_req_i(wb_req), .wb_way_i(wb_way), .wb_addr_i(wb_addr),
    .wb_valid_o(dut_wb_valid), .wb_data_o(dut_wb_data)
  );

  dcache_checker u_check (
    .clk(clk), .rst_n_i(rst_n),
    .rd_valid_i(rd_valid), .rd_addr_i(rd_addr), .rd_hit_i(rd_hit),
    .fill_valid_i(fill_valid), .fill_way_i(fill_way),
    .fill_addr_i(fill_addr), .fill_data_i(fill_data),
    .st_valid_i(st_valid), .st_way_i(st_way), .st_addr_i(st_addr),
    .st_strb_i(st_strb), .st_data_i(st_data),
    .wb_req_i(wb_req), .wb_way_i(wb_way), .wb_addr_i(wb_addr),
    .file_rd_exp_i(exp_word), .file_wb_exp_i(exp_line),
    .dut_rd_valid_i(dut_rd_valid), .dut_rd_data_i(dut_rd_data),
    .dut_wb_valid_i(dut_wb_valid), .dut_wb_data_i(dut_wb_data),
    .rd_errs_o(rd_errs), .wb_errs_o(wb_errs), .pending_o(pending)
  );

  // one edge with all strobes dropped and the last load's hit driven
  task automatic next_cycle();
    @(posedge clk);
    rd_valid    <= 1'b0;
    fill_valid  <= 1'b0;
    st_valid    <= 1'b0;
    wb_req      <= 1'b0;
    rd_hit      <= pending_hit;
    pending_hit = '0;
  endtask

  task automatic idle(int n);
    repeat (n) next_cycle();
  endtask

  task automatic drive_fill(dc_way_t way, dc_addr_t addr, dc_line_t data);
    next_cycle();
    fill_valid <= 1'b1;
    fill_way   <= way;
    fill_addr  <= addr;
    fill_data  <= data;
  endtask

  task automatic drive_store(dc_way_t way, dc_addr_t addr, dc_strb_t strb, dc_word_t data);
    st_valid <= 1'b1;
    st_way   <= way;
    st_addr  <= addr;
    st_strb  <= strb;
    st_data  <= data;
  endtask

  // request now and hit one cycle later
  task automatic drive_read(dc_addr_t addr, dc_hit_t hit, dc_word_t exp);
    rd_valid    <= 1'b1;
    rd_addr     <= addr;
    exp_word    <= exp;
    pending_hit = hit;
  endtask

  task automatic drive_wb(dc_way_t way, dc_addr_t addr, dc_line_t exp);
    next_cycle();
    wb_req   <= 1'b1;
    wb_way   <= way;
    wb_addr  <= addr;
    exp_line <= exp;
  endtask

  function automatic bit fields_ok(int got, int want, byte op);
    if (got == want)
      return 1'b1;
    $display("malformed test data record %c: %0d of %0d fields read", op, got, want);
    other_errs++;
    return 1'b0;
  endfunction

  // steps until the checker has nothing in flight or the limit runs out
  task automatic drain_outputs();
    int waited;
    waited = 0;
    next_cycle();
    @(negedge clk);
    while (pending && waited < DRAIN_LIMIT)
    begin
      next_cycle();
      @(negedge clk);
      waited++;
    end
    if (pending)
    begin
      $display("timeout: load or writeback results still outstanding after %0d cycles", waited);
      other_errs++;
    end
  endtask

  initial
  begin
    int               fd;
    int               n;
    int               count;
    byte              op;
    bit               done;
    logic [31:0]      f_way;
    logic [31:0]      f_addr;
    logic [31:0]      f_strb;
    logic [31:0]      f_word;
    logic [31:0]      f_hit;
    logic [31:0]      f_exp;
    logic [31:0]      f_flag;
    dc_line_t         f_line;
    logic [8*128-1:0] skip;
    clk = 1'b0;
    rst_n = 1'b0;
    rd_valid = 1'b0;
    rd_addr = '0;
    rd_hit = '0;
    fill_valid = 1'b0;
    fill_way = '0;
    fill_addr = '0;
    fill_data = '0;
    st_valid = 1'b0;
    st_way = '0;
    st_addr = '0;
    st_strb = '0;
    st_data = '0;
    wb_req = 1'b0;
    wb_way = '0;
    wb_addr = '0;
    exp_word = '0;
    exp_line = '0;
    pending_hit = '0;
    other_errs = 0;
    seed = 32'hf143_0047;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    fd = $fopen("bench/dcache_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open test data file bench/dcache_testdata.txt");
      other_errs++;
    end
    else
    begin
      done  = 1'b0;
      count = 0;
      while (!done && count < MAX_RECORDS)
      begin
        count++;
        n = $fscanf(fd, " %c", op);
        if (n != 1)
        begin
          $display("test data ended without an end record");
          other_errs++;
          done = 1'b1;
        end
        else if (op == "#")
          n = $fgets(skip, fd);
        else
        begin
          f_flag = 0;
          case (op)
            "F":
            begin
              n = $fscanf(fd, "%h %h %h", f_way, f_addr, f_line);
              if (fields_ok(n, 3, op))
                drive_fill(dc_way_t'(f_way), dc_addr_t'(f_addr), f_line);
            end
            "S":
            begin
              n = $fscanf(fd, "%h %h %h %h", f_way, f_addr, f_strb, f_word);
              if (fields_ok(n, 4, op))
              begin
                next_cycle();
                drive_store(dc_way_t'(f_way), dc_addr_t'(f_addr), dc_strb_t'(f_strb), f_word);
              end
            end
            "R":
            begin
              n = $fscanf(fd, "%h %h %h %h", f_addr, f_hit, f_exp, f_flag);
              if (fields_ok(n, 4, op))
              begin
                next_cycle();
                drive_read(dc_addr_t'(f_addr), dc_hit_t'(f_hit), f_exp);
              end
            end
            "C":
            begin
              // store and load of the same word in one cycle
              n = $fscanf(fd, "%h %h %h %h %h %h", f_way, f_addr, f_strb, f_word, f_hit, f_exp);
              if (fields_ok(n, 6, op))
              begin
                next_cycle();
                drive_store(dc_way_t'(f_way), dc_addr_t'(f_addr), dc_strb_t'(f_strb), f_word);
                drive_read(dc_addr_t'(f_addr), dc_hit_t'(f_hit), f_exp);
              end
            end
            "W":
            begin
              n = $fscanf(fd, "%h %h %h", f_way, f_addr, f_line);
              if (fields_ok(n, 3, op))
              begin
                drive_wb(dc_way_t'(f_way), dc_addr_t'(f_addr), f_line);
                // engine is busy for two cycles after the request
                idle(3);
              end
            end
            "E":
              done = 1'b1;
            default:
            begin
              $display("unknown opcode %c in test data", op);
              other_errs++;
              done = 1'b1;
            end
          endcase
          // chained loads go out back to back
          if (!done && f_flag == 0)
            idle($unsigned($random(seed)) % 3);
        end
      end
      if (!done)
      begin
        $display("test data has more than %0d records", MAX_RECORDS);
        other_errs++;
      end
      $fclose(fd);
    end

    drain_outputs();
    idle(2);
    @(negedge clk);

    $display("errors: load %0d, writeback %0d, other %0d", rd_errs, wb_errs, other_errs);
    if (rd_errs == 0 && wb_errs == 0 && other_errs == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== hw/dcache_data_array.sv ====
// skewed four-bank data array: cpu address fan-out, line lane rotation, read forwarding
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data_array
(
  input  logic                                 clk,
  input  logic                                 rst_n_i,
  dcache_line_if.array                         line,
  input  dcache_pkg::dc_addr_t                 cpu_addr_i,
  output dcache_pkg::dc_word_t [`DC_WAYS-1:0]  cpu_rdata_o,
  output logic [$clog2(`DC_LINE_WORDS)-1:0]    cpu_rot_o
);
  import dcache_pkg::*;

  localparam int AW     = $clog2(`DC_BANK_DEPTH);
  localparam int WORD_W = $bits(dc_word_t);
  localparam int STRB_W = $bits(dc_strb_t);

  // bank layout, word w of way v lives in bank (v + w) mod 4
  //        B0  B1  B2  B3
  //   w0   V0  V1  V2  V3
  //   w1   V3  V0  V1  V2
  //   w2   V2  V3  V0  V1
  //   w3   V1  V2  V3  V0
  // a cpu read of word w hits all ways at once, one per bank
  // a line access of way v touches word (b - v) mod 4 in bank b

  logic [AW-1:0] cpu_bank_addr;
  dc_set_t       line_set;

  logic [AW-1:0] bank_addr1  [`DC_WAYS];
  dc_strb_t      bank_we1    [`DC_WAYS];
  dc_word_t      bank_wdata1 [`DC_WAYS];
  dc_word_t      bank_rdata0 [`DC_WAYS];
  dc_word_t      bank_rdata1 [`DC_WAYS];

  // same-cycle write to the address the cpu port reads, per bank
  logic [`DC_WAYS-1:0] fwd_d;
  logic [`DC_WAYS-1:0] fwd_q;

  // way of the previous line access, undoes the skew on read data
  dc_way_t  way_q;
  dc_line_t line_rdata;

  // cpu port reads set and word in every bank
  assign cpu_bank_addr = cpu_addr_i[`DC_ADDR_W-1:2];
  assign line_set      = line.addr[`DC_ADDR_W-1:`DC_ADDR_W-`DC_SET_W];

  // line port lane select per bank
  always_comb
  begin
    dc_way_t lane;
    for (int b = 0; b < `DC_WAYS; b++)
    begin
      // wraps mod 4 through the 2-bit type
      lane           = dc_way_t'(b) - line.way;
      bank_addr1[b]  = {line_set, lane};
      bank_we1[b]    = line.wstrb[lane*STRB_W +: STRB_W];
      bank_wdata1[b] = line.wdata[lane*WORD_W +: WORD_W];
      fwd_d[b]       = (|bank_we1[b]) && (bank_addr1[b] == cpu_bank_addr);
    end
  end

  for (genvar b = 0; b < `DC_WAYS; b++)
  begin : g_bank
    dcache_dpsram #(
      .DEPTH(`DC_BANK_DEPTH)
    ) u_bank (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .addr0_i  (cpu_bank_addr),
      .rdata0_o (bank_rdata0[b]),
      .addr1_i  (bank_addr1[b]),
      .we1_i    (bank_we1[b]),
      .wdata1_i (bank_wdata1[b]),
      .rdata1_o (bank_rdata1[b])
    );
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      way_q     <= '0;
      cpu_rot_o <= '0;
      fwd_q     <= '0;
    end
    else
    begin
      way_q     <= line.way;
      cpu_rot_o <= cpu_addr_i[3:2];
      fwd_q     <= fwd_d;
    end
  end

  // word w of the line came from bank (w + way) mod 4
  always_comb
  begin
    dc_way_t src;
    for (int w = 0; w < `DC_LINE_WORDS; w++)
    begin
      src = dc_way_t'(w) + way_q;
      line_rdata[w*WORD_W +: WORD_W] = bank_rdata1[src];
    end
  end

  assign line.rdata = line_rdata;

  // port 1 holds the freshly written word when a write collided with the read
  always_comb
  begin
    for (int b = 0; b < `DC_WAYS; b++)
    begin
      cpu_rdata_o[b] = fwd_q[b] ? bank_rdata1[b] : bank_rdata0[b];
    end
  end

endmodule

// ==== hw/dcache_data_top.sv ====
// data-side top level: line engine, banked data array and read aligner
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data_top
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  // cpu load port
  input  logic                  rd_valid_i,
  input  dcache_pkg::dc_addr_t  rd_addr_i,
  input  dcache_pkg::dc_hit_t   rd_hit_i,
  output logic                  rd_valid_o,
  output dcache_pkg::dc_word_t  rd_data_o,
  // refill
  input  logic                  fill_valid_i,
  input  dcache_pkg::dc_way_t   fill_way_i,
  input  dcache_pkg::dc_addr_t  fill_addr_i,
  input  dcache_pkg::dc_line_t  fill_data_i,
  // cpu store
  input  logic                  st_valid_i,
  input  dcache_pkg::dc_way_t   st_way_i,
  input  dcache_pkg::dc_addr_t  st_addr_i,
  input  dcache_pkg::dc_strb_t  st_strb_i,
  input  dcache_pkg::dc_word_t  st_data_i,
  // writeback
  input  logic                  wb_req_i,
  input  dcache_pkg::dc_way_t   wb_way_i,
  input  dcache_pkg::dc_addr_t  wb_addr_i,
  output logic                  wb_valid_o,
  output dcache_pkg::dc_line_t  wb_data_o
);
  import dcache_pkg::*;

  // cpu-side bank words and their skew offset, one cycle after rd_addr_i
  dc_word_t [`DC_WAYS-1:0]           cpu_rdata;
  logic [$clog2(`DC_LINE_WORDS)-1:0] cpu_rot;

  dcache_line_if line_bus ();

  dcache_line_engine u_engine (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .fill_valid_i (fill_valid_i),
    .fill_way_i   (fill_way_i),
    .fill_addr_i  (fill_addr_i),
    .fill_data_i  (fill_data_i),
    .st_valid_i   (st_valid_i),
    .st_way_i     (st_way_i),
    .st_addr_i    (st_addr_i),
    .st_strb_i    (st_strb_i),
    .st_data_i    (st_data_i),
    .wb_req_i     (wb_req_i),
    .wb_way_i     (wb_way_i),
    .wb_addr_i    (wb_addr_i),
    .wb_valid_o   (wb_valid_o),
    .wb_data_o    (wb_data_o),
    .line         (line_bus.engine)
  );

  dcache_data_array u_array (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .line        (line_bus.array),
    .cpu_addr_i  (rd_addr_i),
    .cpu_rdata_o (cpu_rdata),
    .cpu_rot_o   (cpu_rot)
  );

  dcache_read_align u_align (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .bank_rdata_i (cpu_rdata),
    .rot_i        (cpu_rot),
    .hit_i        (rd_hit_i),
    .valid_i      (rd_valid_i),
    .valid_o      (rd_valid_o),
    .data_o       (rd_data_o)
  );

endmodule

// ==== hw/dcache_dpsram.sv ====
// dual-port byte-writable sram bank with read port 0, read/write port 1 and registered reads
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_dpsram
#(
  parameter int DEPTH = `DC_BANK_DEPTH,
  parameter int AW    = $clog2(DEPTH)
)
(
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [AW-1:0]        addr0_i,
  output dcache_pkg::dc_word_t rdata0_o,
  input  logic [AW-1:0]        addr1_i,
  input  dcache_pkg::dc_strb_t we1_i,
  input  dcache_pkg::dc_word_t wdata1_i,
  output dcache_pkg::dc_word_t rdata1_o
);
  import dcache_pkg::*;

  dc_word_t mem [DEPTH];
  // port 1 word after the byte merge that a write-first read returns
  dc_word_t merged;

  always_comb
  begin
    merged = mem[addr1_i];
    for (int i = 0; i < $bits(dc_strb_t); i++)
    begin
      if (we1_i[i])
        merged[8*i +: 8] = wdata1_i[8*i +: 8];
    end
  end

  // port 1 writes only the strobed byte lanes
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < $bits(dc_strb_t); i++)
    begin
      if (we1_i[i])
        mem[addr1_i][8*i +: 8] <= wdata1_i[8*i +: 8];
    end
  end

  // port 0 sees the old word on a same-address write
  // port 1 sees the new one
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rdata0_o <= '0;
      rdata1_o <= '0;
    end
    else
    begin
      rdata0_o <= mem[addr0_i];
      rdata1_o <= merged;
    end
  end

endmodule

// ==== hw/dcache_line_engine.sv ====
// line engine driving fills, stores and writeback reads onto the line port
`timescale 1ns/1ps

module dcache_line_engine
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  fill_valid_i,
  input  dcache_pkg::dc_way_t   fill_way_i,
  input  dcache_pkg::dc_addr_t  fill_addr_i,
  input  dcache_pkg::dc_line_t  fill_data_i,
  input  logic                  st_valid_i,
  input  dcache_pkg::dc_way_t   st_way_i,
  input  dcache_pkg::dc_addr_t  st_addr_i,
  input  dcache_pkg::dc_strb_t  st_strb_i,
  input  dcache_pkg::dc_word_t  st_data_i,
  input  logic                  wb_req_i,
  input  dcache_pkg::dc_way_t   wb_way_i,
  input  dcache_pkg::dc_addr_t  wb_addr_i,
  output logic                  wb_valid_o,
  output dcache_pkg::dc_line_t  wb_data_o,
  dcache_line_if.engine         line
);
  import dcache_pkg::*;

  dc_eng_state_e state_q;
  dc_eng_state_e state_d;

  logic [1:0] req_cnt;
  logic       accept;
  logic       fill_go;
  logic       st_go;
  logic       wb_go;
  dc_line_t   wb_data_q;

  // only a lone strobe in idle is taken and anything else is dropped
  assign req_cnt = 2'(fill_valid_i) + 2'(st_valid_i) + 2'(wb_req_i);
  assign accept  = (state_q == ENG_IDLE) && (req_cnt == 2'd1);
  assign fill_go = accept && fill_valid_i;
  assign st_go   = accept && st_valid_i;
  assign wb_go   = accept && wb_req_i;

  // request goes out on the line port in its own cycle
  // default is a zero-strobe read of the writeback line
  always_comb
  begin
    line.way   = wb_way_i;
    line.addr  = wb_addr_i;
    line.wstrb = '0;
    line.wdata = '0;
    if (fill_go)
    begin
      line.way   = fill_way_i;
      line.addr  = fill_addr_i;
      line.wstrb = '1;
      line.wdata = fill_data_i;
    end
    else if (st_go)
    begin
      // store word sits in lane addr[3:2] and other lanes stay zero
      line.way   = st_way_i;
      line.addr  = st_addr_i;
      line.wstrb = dc_line_strb_t'(st_strb_i) << ($bits(dc_strb_t) * st_addr_i[3:2]);
      line.wdata = dc_line_t'(st_data_i) << ($bits(dc_word_t) * st_addr_i[3:2]);
    end
  end

  // writeback read issued in idle, line back in wb_read and pulse in wb_capture
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ENG_IDLE:
        if (wb_go)
          state_d = ENG_WB_READ;
      ENG_WB_READ:
        state_d = ENG_WB_CAPTURE;
      ENG_WB_CAPTURE:
        state_d = ENG_IDLE;
      default:
        state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_q <= ENG_IDLE;
    else
      state_q <= state_d;
  end

  // line is held until the next writeback overwrites it
  always_ff @(posedge clk)
  begin
    if (state_q == ENG_WB_READ)
      wb_data_q <= line.rdata;
  end

  assign wb_data_o  = wb_data_q;
  assign wb_valid_o = (state_q == ENG_WB_CAPTURE);

endmodule

// ==== hw/dcache_line_if.sv ====
// line-side access bundle of the data array, with engine and array modports
`timescale 1ns/1ps

interface dcache_line_if;
  import dcache_pkg::*;

  // way whose line is accessed
  dc_way_t       way;
  // byte address, only the set bits select the line
  dc_addr_t      addr;
  // per-word byte strobes, zero for a read
  dc_line_strb_t wstrb;
  // write line in word order
  dc_line_t      wdata;
  // line read one cycle after the access, already back in word order
  dc_line_t      rdata;

  // producer side
  modport engine (
    output way,
    output addr,
    output wstrb,
    output wdata,
    input  rdata
  );

  // data array side
  modport array (
    input  way,
    input  addr,
    input  wstrb,
    input  wdata,
    output rdata
  );

endinterface

// ==== hw/dcache_pkg.sv ====
// data cache package: word, line, strobe, way, address, set and hit types, line-engine states
`include "dcache_defs.svh"

package dcache_pkg;

  // one cpu data word
  typedef logic [31:0] dc_word_t;

  // full line, word 0 sits in the low bits
  typedef logic [32*`DC_LINE_WORDS-1:0] dc_line_t;

  // byte enables for one word
  typedef logic [3:0] dc_strb_t;

  // byte enables for a whole line, one group of 4 per word
  // all zero means the access is a read
  typedef logic [4*`DC_LINE_WORDS-1:0] dc_line_strb_t;

  // way number
  typedef logic [$clog2(`DC_WAYS)-1:0] dc_way_t;

  // byte address inside one way
  // [11:4] set, [3:2] word, [1:0] byte
  typedef logic [`DC_ADDR_W-1:0] dc_addr_t;

  // set index
  typedef logic [`DC_SET_W-1:0] dc_set_t;

  // one-hot tag hit, bit v set when way v hits
  typedef logic [`DC_WAYS-1:0] dc_hit_t;

  // line engine fsm
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_WB_READ,
    ENG_WB_CAPTURE
  } dc_eng_state_e;

endpackage

// ==== hw/dcache_read_align.sv ====
// read aligner that rotates the hit vector onto the banks and registers the selected word
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_read_align
(
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  dcache_pkg::dc_word_t [`DC_WAYS-1:0] bank_rdata_i,
  input  logic [$clog2(`DC_LINE_WORDS)-1:0]   rot_i,
  input  dcache_pkg::dc_hit_t                 hit_i,
  input  logic                                valid_i,
  output logic                                valid_o,
  output dcache_pkg::dc_word_t                data_o
);
  import dcache_pkg::*;

  // hit bit v moved to the bank that holds way v's word
  dc_hit_t  bank_hit;
  dc_word_t sel_word;
  // valid lined up with bank data and hit
  logic     valid_s1;

  always_comb
  begin
    // way v sits in bank (v + rot) mod 4, so rotate left by rot
    bank_hit = (hit_i << rot_i) | (hit_i >> (`DC_WAYS - rot_i));
    // and-or select giving zero when nothing hits
    sel_word = '0;
    for (int b = 0; b < `DC_WAYS; b++)
    begin
      sel_word = sel_word | ({$bits(dc_word_t){bank_hit[b]}} & bank_rdata_i[b]);
    end
  end

  // valid moves from request cycle to bank data cycle to output
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_s1 <= 1'b0;
      valid_o  <= 1'b0;
    end
    else
    begin
      valid_s1 <= valid_i;
      valid_o  <= valid_s1;
    end
  end

  always_ff @(posedge clk)
  begin
    data_o <= sel_word;
  end

endmodule

// ==== include/dcache_defs.svh ====
// geometry macros of the data cache: ways, line words, set and address widths, bank depth
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// number of ways, also the number of data banks
`define DC_WAYS 4

// words per line, must equal the way count for the bank skew to work
`define DC_LINE_WORDS 4

// set index width, 256 sets per way
`define DC_SET_W 8

// in-way byte address: set, word, byte
`define DC_ADDR_W 12

// words per bank, one word of every line of one skew column
`define DC_BANK_DEPTH 1024

`endif

// ==== sim.f ====
+incdir+include
hw/dcache_pkg.sv
hw/dcache_line_if.sv
hw/dcache_dpsram.sv
hw/dcache_data_array.sv
hw/dcache_line_engine.sv
hw/dcache_read_align.sv
hw/dcache_data_top.sv
bench/dcache_checker.sv
bench/tb_dcache_top.sv
